// File: hw/id_macros.svh
// widths, opcodes and ALU op codes shared by the decode stage, include where needed
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

`define ID_XLEN         64
`define ID_INST_WD      32
`define ID_GPR_ADDR_WD  5
`define ID_GPR_NUM      32

// rv64i major opcodes kept by this stage
`define ID_OPC_LUI      7'b0110111
`define ID_OPC_JAL      7'b1101111
`define ID_OPC_JALR     7'b1100111
`define ID_OPC_BRANCH   7'b1100011
`define ID_OPC_OP_IMM   7'b0010011
`define ID_OPC_OP       7'b0110011

`define ID_ALU_OP_WD    3
`define ID_ALU_ADD      3'd0  // also lui and jumps
`define ID_ALU_SUB      3'd1
`define ID_ALU_AND      3'd2
`define ID_ALU_OR       3'd3
`define ID_ALU_XOR      3'd4
`define ID_ALU_SLT      3'd5

`endif

// File: hw/id_pkg.sv
// instruction format views for the decode stage, import where the word is decoded
package id_pkg;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_r_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_i_t;

  // branch offset is scattered over the word
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } inst_b_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_u_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_j_t;

  typedef union packed {
    inst_r_t r;
    inst_i_t i;
    inst_b_t b;
    inst_u_t u;
    inst_j_t j;
  } rv_inst_u;

endpackage

// File: hw/id_stage_reg.sv
// decode stage latch with valid/allowin handshake and data hazard stall
`timescale 1ns/1ns
`include "id_macros.svh"

module id_stage_reg import id_pkg::*; (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_fs_valid,
  input  logic [`ID_XLEN-1:0]        i_fs_pc,
  input  logic [`ID_INST_WD-1:0]     i_fs_inst,
  input  logic                       i_es_allowin,
  input  logic [`ID_GPR_ADDR_WD-1:0] i_es_rd,
  input  logic [`ID_GPR_ADDR_WD-1:0] i_ms_rd,
  input  logic [`ID_GPR_ADDR_WD-1:0] i_ws_rd,
  output logic                       o_ds_allowin,
  output logic                       o_ds_valid,
  output logic [`ID_XLEN-1:0]        o_pc,
  output rv_inst_u                   o_inst
);

  logic                       ds_valid;
  logic                       ds_ready_go;
  logic [`ID_GPR_ADDR_WD-1:0] rs1;
  logic [`ID_GPR_ADDR_WD-1:0] rs2;

  // true when a downstream write targets a source of the held instruction
  function automatic logic rd_hit(input logic [`ID_GPR_ADDR_WD-1:0] rd,
                                  input logic [`ID_GPR_ADDR_WD-1:0] src1,
                                  input logic [`ID_GPR_ADDR_WD-1:0] src2);
    return (rd != '0) && ((rd == src1) || (rd == src2));
  endfunction

  assign rs1 = o_inst.r.rs1;  // raw fields, whatever the format
  assign rs2 = o_inst.r.rs2;

  assign ds_ready_go  = !(rd_hit(i_es_rd, rs1, rs2) ||
                          rd_hit(i_ms_rd, rs1, rs2) ||
                          rd_hit(i_ws_rd, rs1, rs2));
  assign o_ds_allowin = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_valid   = ds_valid && ds_ready_go;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_ds_allowin) begin
      o_pc   <= i_fs_pc;
      o_inst <= i_fs_inst;
    end
  end

endmodule

// File: hw/id_decoder.sv
// rv64i subset decoder, turns the held instruction into immediate and control fields
`timescale 1ns/1ns
`include "id_macros.svh"

module id_decoder import id_pkg::*; (
  input  rv_inst_u                   i_inst,
  output logic [`ID_GPR_ADDR_WD-1:0] o_rs1,
  output logic [`ID_GPR_ADDR_WD-1:0] o_rs2,
  output logic [`ID_GPR_ADDR_WD-1:0] o_rd,
  output logic [`ID_XLEN-1:0]        o_imm,
  output logic [`ID_ALU_OP_WD-1:0]   o_alu_op,
  output logic                       o_alu_src2_imm,
  output logic                       o_gpr_wen,
  output logic                       o_is_branch,
  output logic                       o_is_jal,
  output logic                       o_is_jalr,
  output logic [2:0]                 o_funct3,
  output logic                       o_invalid
);

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [`ID_XLEN-1:0] imm_i;
  logic [`ID_XLEN-1:0] imm_b;
  logic [`ID_XLEN-1:0] imm_u;
  logic [`ID_XLEN-1:0] imm_j;
  logic                wen;

  assign opcode   = i_inst.r.opcode;
  assign funct3   = i_inst.r.funct3;
  assign o_funct3 = funct3;

  // sign extended immediates, one per format view
  assign imm_i = {{(`ID_XLEN-12){i_inst.i.imm_11_0[11]}}, i_inst.i.imm_11_0};
  assign imm_b = {{(`ID_XLEN-13){i_inst.b.imm_12}}, i_inst.b.imm_12, i_inst.b.imm_11,
                  i_inst.b.imm_10_5, i_inst.b.imm_4_1, 1'b0};
  assign imm_u = {{(`ID_XLEN-32){i_inst.u.imm_31_12[19]}}, i_inst.u.imm_31_12, 12'b0};
  assign imm_j = {{(`ID_XLEN-21){i_inst.j.imm_20}}, i_inst.j.imm_20, i_inst.j.imm_19_12,
                  i_inst.j.imm_11, i_inst.j.imm_10_1, 1'b0};

  // lui/jal have no rs1, only r and b formats carry rs2
  assign o_rs1 = (opcode == `ID_OPC_LUI || opcode == `ID_OPC_JAL) ? '0 : i_inst.r.rs1;
  assign o_rs2 = (opcode == `ID_OPC_OP || opcode == `ID_OPC_BRANCH) ? i_inst.r.rs2 : '0;

  always_comb begin
    o_imm          = '0;
    o_alu_op       = `ID_ALU_ADD;
    o_alu_src2_imm = 1'b0;
    wen            = 1'b0;
    o_is_branch    = 1'b0;
    o_is_jal       = 1'b0;
    o_is_jalr      = 1'b0;
    o_invalid      = 1'b0;
    case (opcode)
      `ID_OPC_LUI: begin
        o_imm          = imm_u;  // x0 + imm
        o_alu_src2_imm = 1'b1;
        wen            = 1'b1;
      end
      `ID_OPC_JAL: begin
        o_imm          = imm_j;
        o_alu_src2_imm = 1'b1;
        wen            = 1'b1;
        o_is_jal       = 1'b1;
      end
      `ID_OPC_JALR: begin
        o_imm          = imm_i;
        o_alu_src2_imm = 1'b1;
        wen            = 1'b1;
        o_is_jalr      = (funct3 == 3'b000);
        o_invalid      = (funct3 != 3'b000);
      end
      `ID_OPC_BRANCH: begin
        o_imm       = imm_b;
        o_alu_op    = `ID_ALU_SUB;  // compare
        o_invalid   = (funct3 == 3'b010) || (funct3 == 3'b011);
        o_is_branch = !o_invalid;
      end
      `ID_OPC_OP_IMM, `ID_OPC_OP: begin
        o_alu_src2_imm = (opcode == `ID_OPC_OP_IMM);
        o_imm          = (opcode == `ID_OPC_OP_IMM) ? imm_i : '0;
        wen            = 1'b1;
        case (funct3)
          3'b000: begin
            // sub only exists in the register form
            if (opcode == `ID_OPC_OP && i_inst.r.funct7[5]) begin
              o_alu_op = `ID_ALU_SUB;
            end
          end
          3'b010:  o_alu_op = `ID_ALU_SLT;
          3'b100:  o_alu_op = `ID_ALU_XOR;
          3'b110:  o_alu_op = `ID_ALU_OR;
          3'b111:  o_alu_op = `ID_ALU_AND;
          default: o_invalid = 1'b1;
        endcase
      end
      default: o_invalid = 1'b1;
    endcase
  end

  assign o_gpr_wen = wen && !o_invalid;
  assign o_rd      = o_gpr_wen ? i_inst.r.rd : '0;  // no dest when nothing is written

endmodule

// File: hw/id_gpr_file.sv
// general register file, two combinational reads and one write-back port
`timescale 1ns/1ns
`include "id_macros.svh"

module id_gpr_file (
  input  logic                       i_clk,
  input  logic [`ID_GPR_ADDR_WD-1:0] i_raddr1,
  input  logic [`ID_GPR_ADDR_WD-1:0] i_raddr2,
  input  logic                       i_wen,
  input  logic [`ID_GPR_ADDR_WD-1:0] i_waddr,
  input  logic [`ID_XLEN-1:0]        i_wdata,
  output logic [`ID_XLEN-1:0]        o_rdata1,
  output logic [`ID_XLEN-1:0]        o_rdata2
);

  logic [`ID_XLEN-1:0] regs [`ID_GPR_NUM];

  // x0 is never written
  always_ff @(posedge i_clk) begin
    if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// File: hw/id_branch_unit.sv
// branch condition and jump target, result goes back to fetch
`timescale 1ns/1ns
`include "id_macros.svh"

module id_branch_unit (
  input  logic                i_valid,
  input  logic [`ID_XLEN-1:0] i_pc,
  input  logic [`ID_XLEN-1:0] i_rs1_data,
  input  logic [`ID_XLEN-1:0] i_rs2_data,
  input  logic [`ID_XLEN-1:0] i_imm,
  input  logic                i_is_branch,
  input  logic                i_is_jal,
  input  logic                i_is_jalr,
  input  logic [2:0]          i_funct3,
  output logic                o_br_taken,
  output logic [`ID_XLEN-1:0] o_br_target
);

  logic                cond;
  logic [`ID_XLEN-1:0] jalr_sum;

  always_comb begin
    case (i_funct3)
      3'b000:  cond = (i_rs1_data == i_rs2_data);                  // beq
      3'b001:  cond = (i_rs1_data != i_rs2_data);                  // bne
      3'b100:  cond = ($signed(i_rs1_data) < $signed(i_rs2_data));  // blt
      3'b101:  cond = ($signed(i_rs1_data) >= $signed(i_rs2_data)); // bge
      3'b110:  cond = (i_rs1_data < i_rs2_data);                    // bltu
      3'b111:  cond = (i_rs1_data >= i_rs2_data);                   // bgeu
      default: cond = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1_data + i_imm;

  // jalr clears bit 0, everything else is pc relative
  assign o_br_target = i_is_jalr ? {jalr_sum[`ID_XLEN-1:1], 1'b0} : i_pc + i_imm;
  assign o_br_taken  = i_valid && (i_is_jal || i_is_jalr || (i_is_branch && cond));

endmodule

// File: hw/id_stage.sv
// instruction decode stage top, connects latch, decoder, register file and branch unit
`timescale 1ns/1ns
`include "id_macros.svh"

module id_stage import id_pkg::*; (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_fs_valid,
  input  logic [`ID_XLEN-1:0]        i_fs_pc,
  input  logic [`ID_INST_WD-1:0]     i_fs_inst,
  output logic                       o_ds_allowin,
  input  logic                       i_es_allowin,
  input  logic [`ID_GPR_ADDR_WD-1:0] i_es_rd,
  input  logic [`ID_GPR_ADDR_WD-1:0] i_ms_rd,
  input  logic [`ID_GPR_ADDR_WD-1:0] i_ws_rd,
  input  logic                       i_ws_wen,
  input  logic [`ID_GPR_ADDR_WD-1:0] i_ws_waddr,
  input  logic [`ID_XLEN-1:0]        i_ws_wdata,
  output logic                       o_ds_valid,
  output logic [`ID_XLEN-1:0]        o_ds_pc,
  output logic [`ID_XLEN-1:0]        o_rs1_data,
  output logic [`ID_XLEN-1:0]        o_rs2_data,
  output logic [`ID_XLEN-1:0]        o_imm,
  output logic [`ID_ALU_OP_WD-1:0]   o_alu_op,
  output logic                       o_alu_src2_imm,
  output logic [`ID_GPR_ADDR_WD-1:0] o_rd,
  output logic                       o_gpr_wen,
  output logic                       o_invalid,
  output logic                       o_br_taken,
  output logic [`ID_XLEN-1:0]        o_br_target
);

  rv_inst_u                   ds_inst;
  logic [`ID_GPR_ADDR_WD-1:0] rs1;
  logic [`ID_GPR_ADDR_WD-1:0] rs2;
  logic                       is_branch;
  logic                       is_jal;
  logic                       is_jalr;
  logic [2:0]                 funct3;

  id_stage_reg u_stage_reg (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_fs_valid   (i_fs_valid),
    .i_fs_pc      (i_fs_pc),
    .i_fs_inst    (i_fs_inst),
    .i_es_allowin (i_es_allowin),
    .i_es_rd      (i_es_rd),
    .i_ms_rd      (i_ms_rd),
    .i_ws_rd      (i_ws_rd),
    .o_ds_allowin (o_ds_allowin),
    .o_ds_valid   (o_ds_valid),
    .o_pc         (o_ds_pc),
    .o_inst       (ds_inst)
  );

  id_decoder u_decoder (
    .i_inst         (ds_inst),
    .o_rs1          (rs1),
    .o_rs2          (rs2),
    .o_rd           (o_rd),
    .o_imm          (o_imm),
    .o_alu_op       (o_alu_op),
    .o_alu_src2_imm (o_alu_src2_imm),
    .o_gpr_wen      (o_gpr_wen),
    .o_is_branch    (is_branch),
    .o_is_jal       (is_jal),
    .o_is_jalr      (is_jalr),
    .o_funct3       (funct3),
    .o_invalid      (o_invalid)
  );

  // write-back port comes straight from ws
  id_gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wen    (i_ws_wen),
    .i_waddr  (i_ws_waddr),
    .i_wdata  (i_ws_wdata),
    .o_rdata1 (o_rs1_data),
    .o_rdata2 (o_rs2_data)
  );

  id_branch_unit u_branch_unit (
    .i_valid     (o_ds_valid),  // no redirect while stalled
    .i_pc        (o_ds_pc),
    .i_rs1_data  (o_rs1_data),
    .i_rs2_data  (o_rs2_data),
    .i_imm       (o_imm),
    .i_is_branch (is_branch),
    .i_is_jal    (is_jal),
    .i_is_jalr   (is_jalr),
    .i_funct3    (funct3),
    .o_br_taken  (o_br_taken),
    .o_br_target (o_br_target)
  );

endmodule

// File: tests/id_stage_assertions.sv
// handshake assertions for id_stage, attached to the DUT by bind from the testbench
`timescale 1ns/1ns
`include "id_macros.svh"

module id_stage_assertions (
  input logic                i_clk,
  input logic                i_rst,
  input logic                i_es_allowin,
  input logic                i_ds_valid,
  input logic [`ID_XLEN-1:0] i_ds_pc,
  input logic                i_br_taken
);

  // stage comes out of reset empty
  a_valid_after_rst: assert property (@(posedge i_clk) i_rst |=> !i_ds_valid)
    else $error("o_ds_valid high after reset");

  a_taken_needs_valid: assert property (@(posedge i_clk) disable iff (i_rst)
    i_br_taken |-> i_ds_valid)
    else $error("o_br_taken without o_ds_valid");

  // held work stays put while execute refuses it
  a_hold_on_stall: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_ds_valid && !i_es_allowin) |=> (i_ds_valid && $stable(i_ds_pc)))
    else $error("held instruction changed under back-pressure");

endmodule

// File: tests/id_stage_tb.sv
// testbench for id_stage, random stimulus checked against a reference model, run as top
`timescale 1ns/1ns
`include "id_macros.svh"

module id_stage_tb;

  localparam int T1_CYC  = 200;
  localparam int T2_CYC  = 600;
  localparam int T3_CYC  = 300;
  localparam int T4_CYC  = 400;
  localparam int T5_CYC  = 150;
  localparam int MAX_CYC = 2 * (T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC);

  logic                       i_clk;
  logic                       i_rst;
  logic                       i_fs_valid;
  logic [`ID_XLEN-1:0]        i_fs_pc;
  logic [`ID_INST_WD-1:0]     i_fs_inst;
  logic                       o_ds_allowin;
  logic                       i_es_allowin;
  logic [`ID_GPR_ADDR_WD-1:0] i_es_rd;
  logic [`ID_GPR_ADDR_WD-1:0] i_ms_rd;
  logic [`ID_GPR_ADDR_WD-1:0] i_ws_rd;
  logic                       i_ws_wen;
  logic [`ID_GPR_ADDR_WD-1:0] i_ws_waddr;
  logic [`ID_XLEN-1:0]        i_ws_wdata;
  logic                       o_ds_valid;
  logic [`ID_XLEN-1:0]        o_ds_pc;
  logic [`ID_XLEN-1:0]        o_rs1_data;
  logic [`ID_XLEN-1:0]        o_rs2_data;
  logic [`ID_XLEN-1:0]        o_imm;
  logic [`ID_ALU_OP_WD-1:0]   o_alu_op;
  logic                       o_alu_src2_imm;
  logic [`ID_GPR_ADDR_WD-1:0] o_rd;
  logic                       o_gpr_wen;
  logic                       o_invalid;
  logic                       o_br_taken;
  logic [`ID_XLEN-1:0]        o_br_target;

  logic [31:0]         lcg_state;
  logic [`ID_XLEN-1:0] m_regs [`ID_GPR_NUM];  // model register file
  int                  errors;
  int                  checks;
  int                  cycles;

  id_stage id_stage_inst (.*);

  bind id_stage id_stage_assertions asrt_inst (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_es_allowin (i_es_allowin),
    .i_ds_valid   (o_ds_valid),
    .i_ds_pc      (o_ds_pc),
    .i_br_taken   (o_br_taken)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYC) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYC);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // top 16 bits of two steps, low lcg bits are weak
  function automatic logic [31:0] lcg_next();
    logic [15:0] hi;
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    hi = lcg_state[31:16];
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {hi, lcg_state[31:16]};
  endfunction

  function automatic logic [`ID_XLEN-1:0] rand64();
    logic [31:0] hi;
    hi = lcg_next();
    return {hi, lcg_next()};
  endfunction

  task automatic check_data(input string name, input logic [`ID_XLEN-1:0] exp,
                            input logic [`ID_XLEN-1:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL t=%0t %s exp=%h act=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL t=%0t %s exp=%b act=%b", $time, name, exp, act);
    end
  endtask

  task automatic check_ctrl(input logic [`ID_ALU_OP_WD-1:0] exp_alu, act_alu,
                            input logic [`ID_GPR_ADDR_WD-1:0] exp_rd, act_rd,
                            input logic exp_wen, act_wen, exp_inv, act_inv);
    checks++;
    if (exp_alu !== act_alu) begin
      errors++;
      $display("FAIL t=%0t o_alu_op exp=%h act=%h", $time, exp_alu, act_alu);
    end
    if (exp_rd !== act_rd) begin
      errors++;
      $display("FAIL t=%0t o_rd exp=%h act=%h", $time, exp_rd, act_rd);
    end
    if (exp_wen !== act_wen) begin
      errors++;
      $display("FAIL t=%0t o_gpr_wen exp=%b act=%b", $time, exp_wen, act_wen);
    end
    if (exp_inv !== act_inv) begin
      errors++;
      $display("FAIL t=%0t o_invalid exp=%b act=%b", $time, exp_inv, act_inv);
    end
  endtask

  // reference decode from the rv64i encoding
  task automatic model_decode(input logic [31:0] w, output logic [`ID_XLEN-1:0] imm,
                              output logic [2:0] alu, output logic src2,
                              output logic [4:0] rd, output logic wen, output logic inv,
                              output logic [4:0] ra1, output logic [4:0] ra2,
                              output logic br, output logic jal, output logic jalr);
    logic [6:0] opc;
    logic [2:0] f3;
    logic       we;
    opc = w[6:0];
    f3 = w[14:12];
    imm = '0;
    alu = `ID_ALU_ADD;
    src2 = 1'b0;
    we = 1'b0;
    inv = 1'b0;
    br = 1'b0;
    jal = 1'b0;
    jalr = 1'b0;
    case (opc)
      `ID_OPC_LUI: begin
        imm = {{32{w[31]}}, w[31:12], 12'b0};
        src2 = 1'b1;
        we = 1'b1;
      end
      `ID_OPC_JAL: begin
        imm = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        src2 = 1'b1;
        we = 1'b1;
        jal = 1'b1;
      end
      `ID_OPC_JALR: begin
        imm = {{52{w[31]}}, w[31:20]};
        src2 = 1'b1;
        we = 1'b1;
        inv = (f3 != 3'b000);
        jalr = !inv;
      end
      `ID_OPC_BRANCH: begin
        imm = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        alu = `ID_ALU_SUB;
        inv = (f3 == 3'b010) || (f3 == 3'b011);
        br = !inv;
      end
      `ID_OPC_OP_IMM, `ID_OPC_OP: begin
        src2 = (opc == `ID_OPC_OP_IMM);
        imm = src2 ? {{52{w[31]}}, w[31:20]} : '0;
        we = 1'b1;
        case (f3)
          3'b000: alu = (opc == `ID_OPC_OP && w[30]) ? `ID_ALU_SUB : `ID_ALU_ADD;
          3'b010: alu = `ID_ALU_SLT;
          3'b100: alu = `ID_ALU_XOR;
          3'b110: alu = `ID_ALU_OR;
          3'b111: alu = `ID_ALU_AND;
          default: inv = 1'b1;
        endcase
      end
      default: inv = 1'b1;
    endcase
    wen = we && !inv;
    rd = wen ? w[11:7] : 5'd0;
    ra1 = (opc == `ID_OPC_LUI || opc == `ID_OPC_JAL) ? 5'd0 : w[19:15];
    ra2 = (opc == `ID_OPC_OP || opc == `ID_OPC_BRANCH) ? w[24:20] : 5'd0;
  endtask

  // expects the held instruction w at pc to be valid
  task automatic check_outputs(input logic [31:0] w, input logic [`ID_XLEN-1:0] pc);
    logic [`ID_XLEN-1:0] imm, v1, v2, tgt, sum;
    logic [2:0]          alu;
    logic [4:0]          rd, ra1, ra2;
    logic                src2, wen, inv, br, jal, jalr, cond, taken;
    model_decode(w, imm, alu, src2, rd, wen, inv, ra1, ra2, br, jal, jalr);
    v1 = m_regs[ra1];
    v2 = m_regs[ra2];
    case (w[14:12])
      3'b000:  cond = (v1 == v2);
      3'b001:  cond = (v1 != v2);
      3'b100:  cond = ($signed(v1) < $signed(v2));
      3'b101:  cond = ($signed(v1) >= $signed(v2));
      3'b110:  cond = (v1 < v2);
      3'b111:  cond = (v1 >= v2);
      default: cond = 1'b0;
    endcase
    taken = jal || jalr || (br && cond);
    sum = v1 + imm;
    tgt = jalr ? {sum[`ID_XLEN-1:1], 1'b0} : pc + imm;
    check_bit("o_ds_valid", 1'b1, o_ds_valid);
    check_data("o_ds_pc", pc, o_ds_pc);
    check_data("o_rs1_data", v1, o_rs1_data);
    check_data("o_rs2_data", v2, o_rs2_data);
    check_data("o_imm", imm, o_imm);
    check_bit("o_alu_src2_imm", src2, o_alu_src2_imm);
    check_ctrl(alu, o_alu_op, rd, o_rd, wen, o_gpr_wen, inv, o_invalid);
    check_bit("o_br_taken", taken, o_br_taken);
    check_data("o_br_target", tgt, o_br_target);
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [`ID_XLEN-1:0] data);
    i_ws_wen = 1'b1;
    i_ws_waddr = addr;
    i_ws_wdata = data;
    @(negedge i_clk);
    i_ws_wen = 1'b0;
    if (addr != 5'd0) m_regs[addr] = data;
  endtask

  // hands one instruction to the stage, returns at the negedge after acceptance
  task automatic issue(input logic [31:0] w, input logic [`ID_XLEN-1:0] pc);
    i_fs_valid = 1'b1;
    i_fs_inst = w;
    i_fs_pc = pc;
    while (!o_ds_allowin) @(negedge i_clk);
    @(negedge i_clk);
    i_fs_valid = 1'b0;
  endtask

  task automatic run_one(input logic [31:0] w);
    logic [`ID_XLEN-1:0] pc;
    pc = rand64();
    pc[1:0] = 2'b00;
    issue(w, pc);
    check_outputs(w, pc);
    @(negedge i_clk);
  endtask

  function automatic logic [31:0] add_inst(input logic [4:0] rs1, rs2, rd);
    return {7'b0, rs2, rs1, 3'b000, rd, `ID_OPC_OP};
  endfunction

  function automatic logic [6:0] pick_opcode();
    logic [31:0] r;
    logic [6:0]  opc;
    r = lcg_next() % 32'd7;
    case (r)
      32'd0: opc = `ID_OPC_LUI;
      32'd1: opc = `ID_OPC_JAL;
      32'd2: opc = `ID_OPC_JALR;
      32'd3: opc = `ID_OPC_BRANCH;
      32'd4: opc = `ID_OPC_OP_IMM;
      32'd5: opc = `ID_OPC_OP;
      default: begin
        r = lcg_next();
        opc = r[6:0];
        if (opc inside {`ID_OPC_LUI, `ID_OPC_JAL, `ID_OPC_JALR, `ID_OPC_BRANCH,
                        `ID_OPC_OP_IMM, `ID_OPC_OP}) opc = 7'b0000000;
      end
    endcase
    return opc;
  endfunction

  task automatic report_test(input string name, input int base);
    if (errors == base) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - base);
  endtask

  task automatic test_regs();
    int          base;
    logic [31:0] r;
    base = errors;
    write_reg(5'd0, rand64());  // must be dropped
    for (int a = 1; a < `ID_GPR_NUM; a++) write_reg(5'(a), rand64());
    for (int n = 0; n < 60; n++) begin
      r = lcg_next();
      run_one(add_inst(r[9] ? r[4:0] : 5'd0, r[14:10], r[20:16]));
    end
    report_test("register read", base);
  endtask

  task automatic test_decode();
    int          base;
    logic [31:0] r;
    base = errors;
    for (int n = 0; n < 200; n++) begin
      r = lcg_next();
      run_one({r[31:7], pick_opcode()});
    end
    report_test("decode", base);
  endtask

  task automatic test_branch();
    int          base;
    logic [31:0] r;
    logic [6:0]  opc;
    logic [2:0]  f3;
    base = errors;
    for (int n = 0; n < 100; n++) begin
      r = lcg_next();
      case (r[1:0])
        2'd0: opc = `ID_OPC_JAL;
        2'd1: opc = `ID_OPC_JALR;
        default: opc = `ID_OPC_BRANCH;
      endcase
      f3 = r[4:2];
      if (opc == `ID_OPC_JALR) f3 = 3'b000;
      else if (f3 == 3'b010 || f3 == 3'b011) f3 = 3'b000;
      if (r[6:5] == 2'b00) r[24:20] = r[19:15];  // equal operands now and then
      run_one({r[31:15], f3, r[11:7], opc});
    end
    report_test("branch", base);
  endtask

  task automatic test_hazard();
    int          base;
    logic [31:0] r, w;
    logic [4:0]  src, other;
    base = errors;
    for (int n = 0; n < 30; n++) begin
      r = lcg_next();
      w = add_inst(r[4:0] == 5'd0 ? 5'd1 : r[4:0], r[9:5] == 5'd0 ? 5'd2 : r[9:5], r[14:10]);
      if (r[18]) w[6:0] = `ID_OPC_JALR;  // always taken, raw rs2 field is imm
      src = r[15] ? w[24:20] : w[19:15];
      case (r[17:16])
        2'd0: i_es_rd = src;
        2'd1: i_ms_rd = src;
        default: i_ws_rd = src;
      endcase
      issue(w, 64'h1000 + 64'(n * 4));
      repeat (2) begin
        check_bit("o_ds_valid", 1'b0, o_ds_valid);
        check_bit("o_ds_allowin", 1'b0, o_ds_allowin);
        check_bit("o_br_taken", 1'b0, o_br_taken);
        @(negedge i_clk);
      end
      i_es_rd = '0;
      i_ms_rd = '0;
      i_ws_rd = '0;
      #1;
      check_outputs(w, 64'h1000 + 64'(n * 4));
      @(negedge i_clk);
    end
    // zero or unrelated destinations
    for (int n = 0; n < 10; n++) begin
      r = lcg_next();
      other = (r[4:0] == 5'd31) ? 5'd1 : r[4:0] + 5'd1;
      i_ms_rd = other;
      run_one(add_inst(5'd0, r[4:0], r[9:5]));
      i_ms_rd = '0;
    end
    report_test("hazard", base);
  endtask

  task automatic test_backpressure();
    int                  base;
    logic [31:0]         w, nxt, r;
    logic [`ID_XLEN-1:0] pc;
    base = errors;
    for (int n = 0; n < 8; n++) begin
      r = lcg_next();
      w = add_inst(r[4:0], r[9:5], r[14:10]);
      pc = 64'h2000 + 64'(n * 8);
      i_es_allowin = 1'b0;
      issue(w, pc);
      check_outputs(w, pc);
      repeat (3) begin
        r = lcg_next();
        i_fs_valid = 1'b1;
        i_fs_inst = {r[31:7], `ID_OPC_OP_IMM};
        i_fs_pc = rand64();
        @(negedge i_clk);
        check_bit("o_ds_allowin", 1'b0, o_ds_allowin);
        check_outputs(w, pc);  // pc and decode still from the held add
      end
      r = lcg_next();
      nxt = {r[31:7], `ID_OPC_OP_IMM};
      i_fs_inst = nxt;
      i_fs_pc = pc + 64'd4;
      i_es_allowin = 1'b1;
      @(negedge i_clk);
      i_fs_valid = 1'b0;
      check_outputs(nxt, pc + 64'd4);
      @(negedge i_clk);
    end
    report_test("back-pressure", base);
  endtask

  initial begin
    lcg_state = 32'h74e1;
    errors = 0;
    checks = 0;
    cycles = 0;
    i_rst = 1'b1;
    i_fs_valid = 1'b0;
    i_fs_pc = '0;
    i_fs_inst = '0;
    i_es_allowin = 1'b1;
    i_es_rd = '0;
    i_ms_rd = '0;
    i_ws_rd = '0;
    i_ws_wen = 1'b0;
    i_ws_waddr = '0;
    i_ws_wdata = '0;
    for (int a = 0; a < `ID_GPR_NUM; a++) m_regs[a] = '0;
    repeat (8) @(negedge i_clk);
    i_rst = 1'b0;
    check_bit("o_ds_valid", 1'b0, o_ds_valid);
    check_bit("o_br_taken", 1'b0, o_br_taken);
    check_bit("o_ds_allowin", 1'b1, o_ds_allowin);
    test_regs();
    test_decode();
    test_branch();
    test_hazard();
    test_backpressure();
    $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+hw
hw/id_pkg.sv
hw/id_stage_reg.sv
hw/id_decoder.sv
hw/id_gpr_file.sv
hw/id_branch_unit.sv
hw/id_stage.sv
tests/id_stage_assertions.sv
tests/id_stage_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the decode stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module id_stage_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vid_stage_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "=== PASS ===" sim.log; then
  exit 0
fi
exit 1
